//--- l2_mem_pkg.sv
package l2_mem_pkg;

    // System shape
    localparam int num_cores   = 2;
    localparam int queue_depth = 4;
    localparam int max_burst   = 8;

    // Bus widths
    localparam int addr_w    = 30;
    localparam int data_w    = 32;
    localparam int sel_w     = 4;
    localparam int core_id_w = 1;
    localparam int len_w     = 4;
    localparam int cti_w     = 3;
    localparam int bte_w     = 2;

    // Queue bookkeeping, depth is a power of two so pointers wrap naturally
    localparam int ptr_w   = $clog2(queue_depth);
    localparam int count_w = $clog2(queue_depth + 1);

    // Wishbone cycle type identifiers
    localparam logic [cti_w-1:0] cti_classic = 3'd0;
    localparam logic [cti_w-1:0] cti_incr    = 3'd2;
    localparam logic [cti_w-1:0] cti_end     = 3'd7;

    // Bus master states
    localparam int state_w = 2;
    localparam logic [state_w-1:0] st_idle   = 2'd0;
    localparam logic [state_w-1:0] st_bus    = 2'd1;
    localparam logic [state_w-1:0] st_finish = 2'd2;

    // Same 36 bits, meaning chosen by the read flag
    typedef union packed {
        struct packed {
            logic [sel_w-1:0]  sel;
            logic [data_w-1:0] data;
        } wr;
        struct packed {
            logic [data_w-1:0] pad;
            logic [len_w-1:0]  len_m1;
        } rd;
    } l2_payload_u;

    typedef struct packed {
        logic              read;
        logic [addr_w-1:0] addr;
        l2_payload_u       payload;
    } l2_request_t;

endpackage

//--- l2_mem_if.sv
interface l2_mem_if;

    // Request channel, flow controlled by credits
    logic                    req_valid;
    l2_mem_pkg::l2_request_t req;
    logic                    credit_return;

    // Read data, no back-pressure
    logic                            rsp_valid;
    logic [l2_mem_pkg::data_w-1:0]   rsp_data;

    modport core (
        output req_valid,
        output req,
        input  credit_return,
        input  rsp_valid,
        input  rsp_data
    );

    modport adapter (
        input  req_valid,
        input  req,
        output credit_return,
        output rsp_valid,
        output rsp_data
    );

endinterface

//--- l2_request_queue.sv
module l2_request_queue (
    input  logic                    clk,
    input  logic                    arst_n,
    l2_mem_if.adapter               core,
    input  logic                    pop,
    output logic                    not_empty,
    output l2_mem_pkg::l2_request_t head
);

    l2_mem_pkg::l2_request_t entries [l2_mem_pkg::queue_depth];

    logic [l2_mem_pkg::ptr_w-1:0]   wr_ptr;
    logic [l2_mem_pkg::ptr_w-1:0]   rd_ptr;
    logic [l2_mem_pkg::count_w-1:0] count;
    logic                           push;
    logic                           full;

    assign push      = core.req_valid;
    assign not_empty = (count != '0);
    assign full      = (count == l2_mem_pkg::count_w'(l2_mem_pkg::queue_depth));
    assign head      = entries[rd_ptr];

    // Pointers, occupancy and the credit pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr             <= '0;
            rd_ptr             <= '0;
            count              <= '0;
            core.credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per entry sent toward the bus
            core.credit_return <= pop;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= core.req;
        end
    end

    // A core that respects its credits never finds the queue full
    assert property (@(posedge clk) disable iff (!arst_n)
        push |-> !full);

    // Arbiter only grants a queue that holds a request
    assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> not_empty);

endmodule

//--- l2_rr_arbiter.sv
module l2_rr_arbiter (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [l2_mem_pkg::num_cores-1:0]    not_empty,
    input  logic                                busy,
    output logic                                start,
    output logic [l2_mem_pkg::core_id_w-1:0]    grant_id
);

    logic [l2_mem_pkg::core_id_w-1:0] last_id;
    logic [l2_mem_pkg::core_id_w-1:0] pick;
    logic                             found;
    logic                             start_r;

    // Search starts at the core after the last winner
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = last_id;
        for (int i = 1; i <= l2_mem_pkg::num_cores; i++) begin
            idx = (int'(last_id) + i) % l2_mem_pkg::num_cores;
            if (!found && not_empty[idx]) begin
                found = 1'b1;
                pick  = l2_mem_pkg::core_id_w'(idx);
            end
        end
    end

    assign start    = found && !busy && !start_r;
    assign grant_id = pick;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Core 0 gets first priority out of reset
            last_id <= l2_mem_pkg::core_id_w'(l2_mem_pkg::num_cores - 1);
            start_r <= 1'b0;
        end else begin
            start_r <= start;
            if (start) begin
                last_id <= pick;
            end
        end
    end

    // Master takes every grant and turns busy right after it
    assert property (@(posedge clk) disable iff (!arst_n)
        start |=> busy);

endmodule

//--- wishbone_master.sv
module wishbone_master (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            start,
    input  l2_mem_pkg::l2_request_t         request,
    output logic                            busy,
    output logic                            rsp_valid,
    output logic [l2_mem_pkg::data_w-1:0]   rsp_data,
    output logic [l2_mem_pkg::addr_w-1:0]   adr,
    output logic [l2_mem_pkg::data_w-1:0]   dat_w,
    output logic [l2_mem_pkg::sel_w-1:0]    sel,
    output logic                            cyc,
    output logic                            stb,
    output logic                            we,
    output logic [l2_mem_pkg::cti_w-1:0]    cti,
    output logic [l2_mem_pkg::bte_w-1:0]    bte,
    input  logic [l2_mem_pkg::data_w-1:0]   dat_r,
    input  logic                            ack,
    input  logic                            err
);

    logic [l2_mem_pkg::state_w-1:0] state;
    logic [l2_mem_pkg::len_w-1:0]   beats_left;
    logic                           beat_done;
    logic                           last_beat;
    logic                           take;

    assign beat_done = stb && (ack || err);
    // Writes are always one word
    assign last_beat = we || (beats_left == '0);
    assign busy      = (state == l2_mem_pkg::st_bus);
    assign take      = start && !busy;
    // Linear bursts only
    assign bte       = '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= l2_mem_pkg::st_idle;
            cyc        <= 1'b0;
            stb        <= 1'b0;
            we         <= 1'b0;
            beats_left <= '0;
            rsp_valid  <= 1'b0;
        end else begin
            rsp_valid <= beat_done && !we;
            case (state)
                l2_mem_pkg::st_bus: begin
                    if (beat_done) begin
                        if (last_beat) begin
                            state <= l2_mem_pkg::st_finish;
                            cyc   <= 1'b0;
                            stb   <= 1'b0;
                            we    <= 1'b0;
                        end else begin
                            beats_left <= beats_left - 1'b1;
                        end
                    end
                end
                default: begin
                    // Finish carries the last read word out and can take a new grant
                    if (take) begin
                        state      <= l2_mem_pkg::st_bus;
                        cyc        <= 1'b1;
                        stb        <= 1'b1;
                        we         <= !request.read;
                        beats_left <= request.read ? request.payload.rd.len_m1 : '0;
                    end else begin
                        state <= l2_mem_pkg::st_idle;
                    end
                end
            endcase
        end
    end

    // Address, write data and cycle type
    always_ff @(posedge clk) begin
        if (take) begin
            adr <= request.addr;
            if (request.read) begin
                dat_w <= '0;
                sel   <= '1;
                cti   <= (request.payload.rd.len_m1 == '0) ?
                         l2_mem_pkg::cti_end : l2_mem_pkg::cti_incr;
            end else begin
                dat_w <= request.payload.wr.data;
                sel   <= request.payload.wr.sel;
                cti   <= l2_mem_pkg::cti_classic;
            end
        end else if (beat_done) begin
            adr <= adr + 1'b1;
            if (!last_beat) begin
                cti <= (beats_left == l2_mem_pkg::len_w'(1)) ?
                       l2_mem_pkg::cti_end : l2_mem_pkg::cti_incr;
            end
        end
    end

    // Bus error returns zero in place of data
    always_ff @(posedge clk) begin
        if (beat_done && !we) begin
            rsp_data <= err ? '0 : dat_r;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        stb |-> cyc);

    // Core side must never ask for more than the burst limit
    assert property (@(posedge clk) disable iff (!arst_n)
        take && request.read |-> request.payload.rd.len_m1 < l2_mem_pkg::max_burst);

endmodule

//--- wishbone_adapter.sv
module wishbone_adapter (
    input  logic                            clk,
    input  logic                            arst_n,
    l2_mem_if.adapter                       mems [l2_mem_pkg::num_cores-1:0],
    output logic [l2_mem_pkg::addr_w-1:0]   adr,
    output logic [l2_mem_pkg::data_w-1:0]   dat_w,
    output logic [l2_mem_pkg::sel_w-1:0]    sel,
    output logic                            cyc,
    output logic                            stb,
    output logic                            we,
    output logic [l2_mem_pkg::cti_w-1:0]    cti,
    output logic [l2_mem_pkg::bte_w-1:0]    bte,
    input  logic [l2_mem_pkg::data_w-1:0]   dat_r,
    input  logic                            ack,
    input  logic                            err
);

    logic [l2_mem_pkg::num_cores-1:0]   not_empty;
    logic [l2_mem_pkg::num_cores-1:0]   pop;
    l2_mem_pkg::l2_request_t            heads [l2_mem_pkg::num_cores];
    l2_mem_pkg::l2_request_t            granted;
    logic                               start;
    logic                               busy;
    logic [l2_mem_pkg::core_id_w-1:0]   grant_id;
    logic [l2_mem_pkg::core_id_w-1:0]   owner_id;
    logic                               rsp_valid;
    logic [l2_mem_pkg::data_w-1:0]      rsp_data;

    generate
        for (genvar i = 0; i < l2_mem_pkg::num_cores; i++) begin : gen_queues
            assign pop[i] = start && (grant_id == l2_mem_pkg::core_id_w'(i));

            l2_request_queue i_queue (
                .clk       (clk),
                .arst_n    (arst_n),
                .core      (mems[i]),
                .pop       (pop[i]),
                .not_empty (not_empty[i]),
                .head      (heads[i])
            );

            // Only the owner of the current transfer sees the read data
            assign mems[i].rsp_valid = rsp_valid && (owner_id == l2_mem_pkg::core_id_w'(i));
            assign mems[i].rsp_data  = rsp_data;
        end
    endgenerate

    assign granted = heads[grant_id];

    // Owner held from start until the next grant
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            owner_id <= '0;
        end else if (start) begin
            owner_id <= grant_id;
        end
    end

    l2_rr_arbiter i_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .not_empty (not_empty),
        .busy      (busy),
        .start     (start),
        .grant_id  (grant_id)
    );

    wishbone_master i_master (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .request   (granted),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .adr       (adr),
        .dat_w     (dat_w),
        .sel       (sel),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .cti       (cti),
        .bte       (bte),
        .dat_r     (dat_r),
        .ack       (ack),
        .err       (err)
    );

endmodule

//--- l2_mem_top.sv
module l2_mem_top (
    input  logic                                                clk,
    input  logic                                                arst_n,

    // Per-core request ports
    input  logic [l2_mem_pkg::num_cores-1:0]                    req_valid,
    input  logic [l2_mem_pkg::num_cores-1:0]                    req_read,
    input  logic [l2_mem_pkg::num_cores-1:0][l2_mem_pkg::addr_w-1:0] req_addr,
    input  logic [l2_mem_pkg::num_cores-1:0][l2_mem_pkg::len_w-1:0]  req_len,
    input  logic [l2_mem_pkg::num_cores-1:0][l2_mem_pkg::data_w-1:0] req_wdata,
    input  logic [l2_mem_pkg::num_cores-1:0][l2_mem_pkg::sel_w-1:0]  req_sel,
    output logic [l2_mem_pkg::num_cores-1:0]                    credit_return,
    output logic [l2_mem_pkg::num_cores-1:0]                    rsp_valid,
    output logic [l2_mem_pkg::num_cores-1:0][l2_mem_pkg::data_w-1:0] rsp_data,

    // Shared Wishbone bus
    output logic [l2_mem_pkg::addr_w-1:0]                       idbus_adr,
    output logic [l2_mem_pkg::data_w-1:0]                       idbus_dat_w,
    output logic [l2_mem_pkg::sel_w-1:0]                        idbus_sel,
    output logic                                                idbus_cyc,
    output logic                                                idbus_stb,
    output logic                                                idbus_we,
    output logic [l2_mem_pkg::cti_w-1:0]                        idbus_cti,
    output logic [l2_mem_pkg::bte_w-1:0]                        idbus_bte,
    input  logic [l2_mem_pkg::data_w-1:0]                       idbus_dat_r,
    input  logic                                                idbus_ack,
    input  logic                                                idbus_err
);

    l2_mem_if mem [l2_mem_pkg::num_cores-1:0] ();

    generate
        for (genvar i = 0; i < l2_mem_pkg::num_cores; i++) begin : gen_cores
            l2_mem_pkg::l2_request_t request;

            // req_len counts words, the payload stores length minus one
            always_comb begin
                request.read = req_read[i];
                request.addr = req_addr[i];
                if (req_read[i]) begin
                    request.payload.rd.pad    = '0;
                    request.payload.rd.len_m1 = req_len[i] - 1'b1;
                end else begin
                    request.payload.wr.sel  = req_sel[i];
                    request.payload.wr.data = req_wdata[i];
                end
            end

            assign mem[i].req_valid = req_valid[i];
            assign mem[i].req       = request;
            assign credit_return[i] = mem[i].credit_return;
            assign rsp_valid[i]     = mem[i].rsp_valid;
            assign rsp_data[i]      = mem[i].rsp_data;
        end
    endgenerate

    wishbone_adapter i_adapter (
        .clk    (clk),
        .arst_n (arst_n),
        .mems   (mem),
        .adr    (idbus_adr),
        .dat_w  (idbus_dat_w),
        .sel    (idbus_sel),
        .cyc    (idbus_cyc),
        .stb    (idbus_stb),
        .we     (idbus_we),
        .cti    (idbus_cti),
        .bte    (idbus_bte),
        .dat_r  (idbus_dat_r),
        .ack    (idbus_ack),
        .err    (idbus_err)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Reset held low for the first two rising edges
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #5 arst_n = 1'b1;
    end

endmodule

//--- tb_l2_mem_top.sv
module tb_l2_mem_top;

    localparam int n           = l2_mem_pkg::num_cores;
    localparam int drive_delay = 5;
    localparam int mem_words   = 512;
    localparam int write_reqs  = 20;
    localparam int mixed_reqs  = 70;
    // 200 requests, about 4 beats each on average, up to 4 cycles a beat, 25 percent margin
    localparam int max_cycles  = 200 * 4 * 4 * 5 / 4;
    localparam logic [l2_mem_pkg::addr_w-1:0] err_addr = 30'h1ff;

    typedef struct packed {
        logic                          read;
        logic [l2_mem_pkg::addr_w-1:0] addr;
        logic [l2_mem_pkg::len_w-1:0]  len;
    } xfer_t;

    logic clk;
    logic arst_n;

    logic [n-1:0]                          req_valid;
    logic [n-1:0]                          req_read;
    logic [n-1:0][l2_mem_pkg::addr_w-1:0]  req_addr;
    logic [n-1:0][l2_mem_pkg::len_w-1:0]   req_len;
    logic [n-1:0][l2_mem_pkg::data_w-1:0]  req_wdata;
    logic [n-1:0][l2_mem_pkg::sel_w-1:0]   req_sel;
    logic [n-1:0]                          credit_return;
    logic [n-1:0]                          rsp_valid;
    logic [n-1:0][l2_mem_pkg::data_w-1:0]  rsp_data;
    logic [l2_mem_pkg::addr_w-1:0]         idbus_adr;
    logic [l2_mem_pkg::data_w-1:0]         idbus_dat_w;
    logic [l2_mem_pkg::sel_w-1:0]          idbus_sel;
    logic                                  idbus_cyc;
    logic                                  idbus_stb;
    logic                                  idbus_we;
    logic [l2_mem_pkg::cti_w-1:0]          idbus_cti;
    logic [l2_mem_pkg::bte_w-1:0]          idbus_bte;
    logic [l2_mem_pkg::data_w-1:0]         idbus_dat_r;
    logic                                  idbus_ack;
    logic                                  idbus_err;

    int          seed;
    int          cycles;
    int          credits  [n];
    int          sent     [n];
    int          returned [n];
    int          in_queue [n];
    logic [31:0] ref_mem [mem_words];
    logic [31:0] bus_mem [mem_words];
    logic [31:0] exp_q [n][$];
    xfer_t       xfer_q [n][$];

    // Monitor results, set on the falling edge and checked on the rising edge
    logic [n-1:0] rsp_ok;
    logic [31:0]  rsp_got [n];
    logic [31:0]  rsp_exp [n];
    logic         xfer_ok;
    logic         beat_ok;
    logic         fair_ok;
    logic         drained;
    logic         cyc_prev;
    logic         have_prev;
    logic         both_pending;
    int           prev_owner;
    int           beats_left;
    logic [29:0]  beat_addr;

    tb_clock_gen i_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    l2_mem_top i_l2_mem_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req_read      (req_read),
        .req_addr      (req_addr),
        .req_len       (req_len),
        .req_wdata     (req_wdata),
        .req_sel       (req_sel),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .idbus_adr     (idbus_adr),
        .idbus_dat_w   (idbus_dat_w),
        .idbus_sel     (idbus_sel),
        .idbus_cyc     (idbus_cyc),
        .idbus_stb     (idbus_stb),
        .idbus_we      (idbus_we),
        .idbus_cti     (idbus_cti),
        .idbus_bte     (idbus_bte),
        .idbus_dat_r   (idbus_dat_r),
        .idbus_ack     (idbus_ack),
        .idbus_err     (idbus_err)
    );

    task automatic fail_now(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    function automatic logic [31:0] fill_word(input int i);
        return (32'(i) * 32'h0101_0101) ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic drain_complete();
        logic done;
        done = !idbus_cyc;
        for (int c = 0; c < n; c++) begin
            done = done && (exp_q[c].size() == 0) && (xfer_q[c].size() == 0);
        end
        return done;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
        req_valid = '0;
    endtask

    // Core model: updates its memory view and scoreboard, then drives one request
    task automatic send_request(input int c, input logic read, input logic [29:0] addr,
                                input int len, input logic [31:0] data,
                                input logic [3:0] sel);
        xfer_t      x;
        logic [8:0] a;
        if (read) begin
            for (int i = 0; i < len; i++) begin
                a = addr[8:0] + 9'(i);
                exp_q[c].push_back((a == err_addr[8:0]) ? 32'h0 : ref_mem[a]);
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    ref_mem[addr[8:0]][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        x.read = read;
        x.addr = addr;
        x.len  = l2_mem_pkg::len_w'(len);
        xfer_q[c].push_back(x);
        req_valid[c] = 1'b1;
        req_read[c]  = read;
        req_addr[c]  = addr;
        req_len[c]   = l2_mem_pkg::len_w'(len);
        req_wdata[c] = data;
        req_sel[c]   = sel;
        credits[c]   = credits[c] - 1;
        sent[c]      = sent[c] + 1;
    endtask

    task automatic send_random(input int c, input logic mixed);
        logic        read;
        int          offset;
        int          len;
        logic [31:0] data;
        logic [3:0]  sel;
        read   = mixed && (($random(seed) & 1) != 0);
        offset = $unsigned($random(seed)) % 56;
        len    = read ? 1 + ($unsigned($random(seed)) % 8) : 1;
        data   = $random(seed);
        sel    = 4'($random(seed));
        send_request(c, read, 30'(c * 256 + offset), len, data, sel);
    endtask

    task automatic run_phase(input int count, input logic mixed);
        int left [n];
        for (int c = 0; c < n; c++) begin
            left[c] = count;
        end
        while (left[0] > 0 || left[1] > 0) begin
            next_cycle();
            for (int c = 0; c < n; c++) begin
                if (left[c] > 0 && credits[c] > 0 && ($random(seed) & 3) != 0) begin
                    send_random(c, mixed);
                    left[c] = left[c] - 1;
                end
            end
        end
    endtask

    initial begin : stimulus
        seed         = 32'hddde;
        cycles       = 0;
        req_valid    = '0;
        req_read     = '0;
        req_addr     = '0;
        req_len      = '0;
        req_wdata    = '0;
        req_sel      = '0;
        rsp_ok       = '1;
        xfer_ok      = 1'b1;
        beat_ok      = 1'b1;
        fair_ok      = 1'b1;
        drained      = 1'b0;
        cyc_prev     = 1'b0;
        have_prev    = 1'b0;
        both_pending = 1'b0;
        for (int c = 0; c < n; c++) begin
            credits[c]  = l2_mem_pkg::queue_depth;
            sent[c]     = 0;
            returned[c] = 0;
            in_queue[c] = 0;
        end
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = fill_word(i);
            bus_mem[i] = fill_word(i);
        end
        @(posedge arst_n);
        run_phase(write_reqs, 1'b0);
        run_phase(mixed_reqs, 1'b1);
        // Top word of core 1's range answers with a bus error
        do next_cycle(); while (credits[1] == 0);
        send_request(1, 1'b1, err_addr, 1, 32'h0, 4'h0);
        do next_cycle(); while (!drain_complete());
        drained = 1'b1;
        repeat (2) next_cycle();
        $display("PASS: all tests");
        $finish;
    end

    // Wishbone memory with 0 to 3 wait cycles per beat
    initial begin : bus_memory
        int         wait_left;
        logic       in_beat;
        logic [8:0] a;
        idbus_ack   = 1'b0;
        idbus_err   = 1'b0;
        idbus_dat_r = '0;
        in_beat     = 1'b0;
        wait_left   = 0;
        forever begin
            @(posedge clk);
            #drive_delay;
            idbus_ack = 1'b0;
            idbus_err = 1'b0;
            if (idbus_cyc && idbus_stb) begin
                a = idbus_adr[8:0];
                if (!in_beat) begin
                    in_beat   = 1'b1;
                    wait_left = $unsigned($random(seed)) % 4;
                end
                if (wait_left > 0) begin
                    wait_left = wait_left - 1;
                end else begin
                    in_beat = 1'b0;
                    if (a == err_addr[8:0]) begin
                        idbus_err   = 1'b1;
                        idbus_dat_r = 32'hdead_beef;
                    end else begin
                        idbus_ack = 1'b1;
                        if (idbus_we) begin
                            for (int b = 0; b < 4; b++) begin
                                if (idbus_sel[b]) begin
                                    bus_mem[a][8*b +: 8] = idbus_dat_w[8*b +: 8];
                                end
                            end
                        end else begin
                            idbus_dat_r = bus_mem[a];
                        end
                    end
                end
            end
        end
    end

    always @(negedge clk) begin : monitor
        xfer_t      x;
        int         owner;
        logic [2:0] exp_cti;
        if (arst_n) begin
            for (int c = 0; c < n; c++) begin
                if (credit_return[c]) begin
                    credits[c]  = credits[c] + 1;
                    returned[c] = returned[c] + 1;
                end
                rsp_ok[c] = 1'b1;
                if (rsp_valid[c]) begin
                    rsp_got[c] = rsp_data[c];
                    if (exp_q[c].size() == 0) begin
                        rsp_exp[c] = 'x;
                        rsp_ok[c]  = 1'b0;
                    end else begin
                        rsp_exp[c] = exp_q[c].pop_front();
                        rsp_ok[c]  = (rsp_got[c] == rsp_exp[c]);
                    end
                end
            end
            xfer_ok = 1'b1;
            beat_ok = 1'b1;
            fair_ok = 1'b1;
            // New transfer, owner told apart by address range
            if (idbus_cyc && !cyc_prev) begin
                owner = (idbus_adr >= 30'h100) ? 1 : 0;
                if (xfer_q[owner].size() == 0) begin
                    xfer_ok = 1'b0;
                end else begin
                    x          = xfer_q[owner].pop_front();
                    xfer_ok    = (x.read == !idbus_we) && (x.addr == idbus_adr);
                    beats_left = int'(x.len);
                    beat_addr  = x.addr;
                end
                if (have_prev && both_pending) begin
                    fair_ok = (owner != prev_owner);
                end
                have_prev       = 1'b1;
                prev_owner      = owner;
                in_queue[owner] = in_queue[owner] - 1;
            end
            if (idbus_cyc && idbus_stb) begin
                if (idbus_we) begin
                    exp_cti = 3'd0;
                end else begin
                    exp_cti = (beats_left == 1) ? 3'd7 : 3'd2;
                end
                beat_ok = (idbus_cti == exp_cti) && (idbus_adr == beat_addr) &&
                          (idbus_bte == 2'd0);
                if (idbus_ack || idbus_err) begin
                    beats_left = beats_left - 1;
                    beat_addr  = beat_addr + 1'b1;
                end
            end
            cyc_prev     = idbus_cyc;
            both_pending = (in_queue[0] > 0) && (in_queue[1] > 0);
            for (int c = 0; c < n; c++) begin
                in_queue[c] = in_queue[c] + int'(req_valid[c]);
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) idbus_stb |-> idbus_cyc)
        else fail_now("stb high without cyc");

    assert property (@(posedge clk) $rose(arst_n) |->
        !idbus_cyc && !idbus_stb && !idbus_we && rsp_valid == '0 && credit_return == '0)
        else fail_now("outputs not low out of reset");

    assert property (@(posedge clk) disable iff (!arst_n) xfer_ok)
        else fail_now("bus transfer does not match the oldest request of its core");

    assert property (@(posedge clk) disable iff (!arst_n) beat_ok)
        else fail_now("bus beat with wrong address, cti or bte");

    assert property (@(posedge clk) disable iff (!arst_n) fair_ok)
        else fail_now("same core granted twice while the other core was waiting");

    for (genvar c = 0; c < n; c++) begin : gen_core_checks
        assert property (@(posedge clk) disable iff (!arst_n) rsp_ok[c])
            else fail_now($sformatf("core %0d read word %h, expected %h",
                                    c, rsp_got[c], rsp_exp[c]));

        assert property (@(posedge clk) disable iff (!arst_n)
            credits[c] >= 0 && credits[c] <= l2_mem_pkg::queue_depth)
            else fail_now($sformatf("core %0d credit count %0d", c, credits[c]));

        assert property (@(posedge clk) disable iff (!arst_n)
            drained |-> returned[c] == sent[c])
            else fail_now($sformatf("core %0d got %0d credits back for %0d requests",
                                    c, returned[c], sent[c]));
    end

endmodule

//--- verilog.f
l2_mem_pkg.sv
l2_mem_if.sv
l2_request_queue.sv
l2_rr_arbiter.sv
wishbone_master.sv
wishbone_adapter.sv
l2_mem_top.sv
tb_clock_gen.sv
tb_l2_mem_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l2_mem_top -f verilog.f -o tb_l2_mem_top

# A failing run still leaves its log for the search below
./obj_dir/tb_l2_mem_top 2>&1 | tee sim.log || true

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
